//--- common/smartnic_250mhz_consts.svh
`ifndef SMARTNIC_250MHZ_CONSTS_SVH
`define SMARTNIC_250MHZ_CONSTS_SVH

// Stream widths
`define SNIC_DATA_W       64
`define SNIC_KEEP_W       8
`define SNIC_TUSER_W      16
`define SNIC_RSS_W        12

// Register access widths
`define SNIC_ADDR_W       32
`define SNIC_OFF_W        12
`define SNIC_REG_W        32

`define SNIC_ID           32'h0250_C0DE

// Register offsets within the block
`define SNIC_REG_ID       12'h000
`define SNIC_REG_SCRATCH  12'h004
`define SNIC_REG_H2C_PKTS 12'h008
`define SNIC_REG_C2H_PKTS 12'h00C
`define SNIC_REG_CTRL     12'h010

// Port codes written into the sideband dst field
`define SNIC_H2C_DST      16'h0040
`define SNIC_C2H_DST      16'h0001

// Core reset hold, in cycles
`define SNIC_RST_HOLD     8

`endif

//--- common/smartnic_axis_pkg.sv
`include "smartnic_250mhz_consts.svh"

package smartnic_axis_pkg;

    // ----------------------------------------
    // Sideband
    // ----------------------------------------
    typedef struct packed {
        logic [`SNIC_TUSER_W-1:0] size;
        logic [`SNIC_TUSER_W-1:0] src;
        logic [`SNIC_TUSER_W-1:0] dst;
    } tuser_h2c_t;

    // Receive side also carries the RSS hash, passed through untouched
    typedef struct packed {
        logic [`SNIC_TUSER_W-1:0] size;
        logic [`SNIC_TUSER_W-1:0] src;
        logic [`SNIC_TUSER_W-1:0] dst;
        logic                     rss_hash_valid;
        logic [`SNIC_RSS_W-1:0]   rss_hash;
    } tuser_c2h_t;

    // ----------------------------------------
    // Stream beats
    // ----------------------------------------
    typedef struct packed {
        logic [`SNIC_DATA_W-1:0] tdata;
        logic [`SNIC_KEEP_W-1:0] tkeep;
        logic                    tlast;
        tuser_h2c_t              tuser;
    } axis_h2c_beat_t;

    typedef struct packed {
        logic [`SNIC_DATA_W-1:0] tdata;
        logic [`SNIC_KEEP_W-1:0] tkeep;
        logic                    tlast;
        tuser_c2h_t              tuser;
    } axis_c2h_beat_t;

endpackage : smartnic_axis_pkg

//--- common/smartnic_reg_pkg.sv
`include "smartnic_250mhz_consts.svh"

package smartnic_reg_pkg;

    // Held by the host for the whole request phase
    typedef struct packed {
        logic [`SNIC_ADDR_W-1:0] addr;
        logic [`SNIC_REG_W-1:0]  wdata;
        logic                    wr;
    } reg_cmd_t;

    // Valid while ack is high
    typedef struct packed {
        logic [`SNIC_REG_W-1:0] rdata;
        logic                   err;
    } reg_rsp_t;

    // Single-cycle operation, decoder to register block
    typedef struct packed {
        logic                   valid;
        logic [`SNIC_OFF_W-1:0] offset;
        logic [`SNIC_REG_W-1:0] wdata;
        logic                   wr;
    } reg_op_t;

endpackage : smartnic_reg_pkg

//--- regs/smartnic_250mhz_decoder.sv
`include "smartnic_250mhz_consts.svh"

module smartnic_250mhz_decoder (
    input  logic                       i_axis_aclk,
    input  logic                       i_core_rst_n,
    input  logic                       i_req,
    input  smartnic_reg_pkg::reg_cmd_t i_reg_cmd,
    output logic                       o_ack,
    output smartnic_reg_pkg::reg_rsp_t o_reg_rsp,
    output smartnic_reg_pkg::reg_op_t  o_op,
    input  smartnic_reg_pkg::reg_rsp_t i_op_rsp
);

    import smartnic_reg_pkg::*;

    localparam reg_rsp_t MISS_RSP = '{rdata: '0, err: 1'b1};

    logic     busy;
    logic     start;
    logic     blk_hit;
    logic [1:0] pend;
    logic [1:0] miss;

    // A held request after ack is not a new one
    assign start   = i_req && !busy;
    assign blk_hit = (i_reg_cmd.addr[`SNIC_ADDR_W-1:`SNIC_OFF_W] == '0);

    // ----------------------------------------
    // Request front end and ack
    // ----------------------------------------
    always_ff @(posedge i_axis_aclk) begin
        if (!i_core_rst_n) begin
            busy  <= 1'b0;
            pend  <= '0;
            miss  <= '0;
            o_op  <= '0;
            o_ack <= 1'b0;
        end else begin
            o_op.valid <= start && blk_hit;
            if (start) begin
                o_op.offset <= i_reg_cmd.addr[`SNIC_OFF_W-1:0];
                o_op.wdata  <= i_reg_cmd.wdata;
                o_op.wr     <= i_reg_cmd.wr;
                busy        <= 1'b1;
            end else if (o_ack && !i_req) begin
                busy <= 1'b0;
            end

            // Misses follow the same two-stage schedule as hits
            pend <= {pend[0], start};
            miss <= {miss[0], start && !blk_hit};

            if (pend[1]) begin
                o_ack <= 1'b1;
            end else if (!i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    // Response return captured together with the ack
    always_ff @(posedge i_axis_aclk) begin
        if (pend[1]) begin
            o_reg_rsp <= miss[1] ? MISS_RSP : i_op_rsp;
        end
    end

endmodule : smartnic_250mhz_decoder

//--- regs/smartnic_250mhz_reg_blk.sv
`include "smartnic_250mhz_consts.svh"

module smartnic_250mhz_reg_blk (
    input  logic                       i_axis_aclk,
    input  logic                       i_core_rst_n,
    input  smartnic_reg_pkg::reg_op_t  i_op,
    output smartnic_reg_pkg::reg_rsp_t o_op_rsp,
    input  logic                       i_h2c_out_valid,
    input  logic                       i_h2c_out_ready,
    input  logic                       i_h2c_out_last,
    input  logic                       i_c2h_out_valid,
    input  logic                       i_c2h_out_ready,
    input  logic                       i_c2h_out_last
);

    import smartnic_reg_pkg::*;

    logic [`SNIC_REG_W-1:0] scratch;
    logic [`SNIC_REG_W-1:0] h2c_pkts;
    logic [`SNIC_REG_W-1:0] c2h_pkts;
    logic                   wr_en;
    logic                   cnt_clr;
    logic                   h2c_eop;
    logic                   c2h_eop;
    reg_rsp_t               rsp_d;

    assign wr_en   = i_op.valid && i_op.wr;
    assign cnt_clr = wr_en && (i_op.offset == `SNIC_REG_CTRL) && i_op.wdata[0];

    // Packet ends as seen at the path outputs
    assign h2c_eop = i_h2c_out_valid && i_h2c_out_ready && i_h2c_out_last;
    assign c2h_eop = i_c2h_out_valid && i_c2h_out_ready && i_c2h_out_last;

    // ----------------------------------------
    // Read data and offset check
    // ----------------------------------------
    always_comb begin
        rsp_d = '0;
        case (i_op.offset)
            `SNIC_REG_ID:       rsp_d.rdata = `SNIC_ID;
            `SNIC_REG_SCRATCH:  rsp_d.rdata = scratch;
            `SNIC_REG_H2C_PKTS: rsp_d.rdata = h2c_pkts;
            `SNIC_REG_C2H_PKTS: rsp_d.rdata = c2h_pkts;
            `SNIC_REG_CTRL:     rsp_d.rdata = '0;
            default:            rsp_d.err   = 1'b1;
        endcase
        // Writes answer with zero data
        if (i_op.wr) begin
            rsp_d.rdata = '0;
        end
    end

    always_ff @(posedge i_axis_aclk) begin
        if (i_op.valid) begin
            o_op_rsp <= rsp_d;
        end
    end

    // ----------------------------------------
    // Scratch and packet counters
    // ----------------------------------------
    always_ff @(posedge i_axis_aclk) begin
        if (!i_core_rst_n) begin
            scratch  <= '0;
            h2c_pkts <= '0;
            c2h_pkts <= '0;
        end else begin
            if (wr_en && (i_op.offset == `SNIC_REG_SCRATCH)) begin
                scratch <= i_op.wdata;
            end
            // Clear wins over a packet ending in the same cycle
            if (cnt_clr) begin
                h2c_pkts <= '0;
                c2h_pkts <= '0;
            end else begin
                if (h2c_eop) begin
                    h2c_pkts <= h2c_pkts + 1'b1;
                end
                if (c2h_eop) begin
                    c2h_pkts <= c2h_pkts + 1'b1;
                end
            end
        end
    end

endmodule : smartnic_250mhz_reg_blk

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f smartnic_250mhz.f --top-module smartnic_250mhz_tb -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- smartnic_250mhz.f
+incdir+common
common/smartnic_axis_pkg.sv
common/smartnic_reg_pkg.sv
verilog/axis_reg_slice.sv
verilog/smartnic_250mhz_reset.sv
regs/smartnic_250mhz_decoder.sv
regs/smartnic_250mhz_reg_blk.sv
verilog/smartnic_250mhz.sv
verif/smartnic_250mhz_assertions.sv
verif/smartnic_250mhz_tb.sv

//--- verif/smartnic_250mhz_assertions.sv
module smartnic_250mhz_assertions (
    input logic                              i_clk,
    input logic                              i_rst_done,
    input logic                              i_req,
    input logic                              i_ack,
    input logic                              i_h2c_ready,
    input logic                              i_rx_ready,
    input logic                              i_tx_valid,
    input logic                              i_tx_ready,
    input smartnic_axis_pkg::axis_h2c_beat_t i_tx_beat,
    input logic                              i_c2h_valid,
    input logic                              i_c2h_ready,
    input smartnic_axis_pkg::axis_c2h_beat_t i_c2h_beat
);

    // Ack only answers a live request
    ack_needs_req: assert property (@(posedge i_clk) $rose(i_ack) |-> i_req)
        else $error("o_ack rose while i_req was low");

    // Stalled beats hold still
    tx_stable: assert property (@(posedge i_clk) disable iff (!i_rst_done)
        i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_beat))
        else $error("TX beat changed while stalled");

    c2h_stable: assert property (@(posedge i_clk) disable iff (!i_rst_done)
        i_c2h_valid && !i_c2h_ready |=> i_c2h_valid && $stable(i_c2h_beat))
        else $error("C2H beat changed while stalled");

    // One cycle of slack while the core reset reaches the slices
    quiet_in_reset: assert property (@(posedge i_clk)
        !i_rst_done && !$past(i_rst_done) |->
            !i_tx_valid && !i_c2h_valid && !i_ack && !i_h2c_ready && !i_rx_ready)
        else $error("Activity while the core is held in reset");

endmodule : smartnic_250mhz_assertions

bind smartnic_250mhz smartnic_250mhz_assertions i_smartnic_250mhz_assertions (
    .i_clk       (i_axis_aclk),
    .i_rst_done  (o_rst_done),
    .i_req       (i_req),
    .i_ack       (o_ack),
    .i_h2c_ready (o_h2c_ready),
    .i_rx_ready  (o_rx_ready),
    .i_tx_valid  (o_tx_valid),
    .i_tx_ready  (i_tx_ready),
    .i_tx_beat   (o_tx_beat),
    .i_c2h_valid (o_c2h_valid),
    .i_c2h_ready (i_c2h_ready),
    .i_c2h_beat  (o_c2h_beat)
);

//--- verif/smartnic_250mhz_stim.txt
# W addr wdata err | R addr rdata err | P path(0=H2C,1=C2H) beats | M = module reset
# All numbers hex; a write always expects rdata 0
R 00000000 0250C0DE 0
R 00000008 00000000 0
R 0000000C 00000000 0
R 00000010 00000000 0
W 00000004 A5A55A5A 0
R 00000004 A5A55A5A 0
W 00000004 12345678 0
R 00000004 12345678 0
W 00000000 FFFFFFFF 0
R 00000000 0250C0DE 0
R 00000014 00000000 1
W 00000014 DEADBEEF 1
R 00000002 00000000 1
R 00010004 00000000 1
W 00010004 FFFFFFFF 1
R 00000004 12345678 0
P 0 3
P 1 1
P 0 1
P 1 5
P 0 6
P 1 2
R 00000008 00000003 0
R 0000000C 00000003 0
W 00000010 00000001 0
R 00000008 00000000 0
R 0000000C 00000000 0
P 0 2
P 1 4
R 00000008 00000001 0
R 0000000C 00000001 0
W 00000004 CAFEF00D 0
M
R 00000004 00000000 0
R 00000008 00000000 0
R 0000000C 00000000 0
R 00000000 0250C0DE 0

//--- verif/smartnic_250mhz_tb.sv
`include "smartnic_250mhz_consts.svh"

module smartnic_250mhz_tb;

    import smartnic_axis_pkg::*;
    import smartnic_reg_pkg::*;

    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } stim_t;

    logic           clk;
    logic           rst_n;
    logic           mod_rstn;
    logic           rst_done;
    logic           req;
    reg_cmd_t       reg_cmd;
    logic           ack;
    reg_rsp_t       reg_rsp;
    logic           h2c_valid;
    axis_h2c_beat_t h2c_beat;
    logic           h2c_ready;
    logic           tx_valid;
    axis_h2c_beat_t tx_beat;
    logic           tx_ready;
    logic           rx_valid;
    axis_c2h_beat_t rx_beat;
    logic           rx_ready;
    logic           c2h_valid;
    axis_c2h_beat_t c2h_beat;
    logic           c2h_ready;

    axis_h2c_beat_t exp_h2c[$];
    axis_c2h_beat_t exp_c2h[$];
    stim_t          cmds[$];
    stim_t          s;
    string          line;
    int             fd;
    int             cycle_cnt = 0;
    int             cycle_limit = 100000;

    smartnic_250mhz UUT (
        .i_axis_aclk (clk),
        .i_rst_n     (rst_n),
        .i_mod_rstn  (mod_rstn),
        .o_rst_done  (rst_done),
        .i_req       (req),
        .i_reg_cmd   (reg_cmd),
        .o_ack       (ack),
        .o_reg_rsp   (reg_rsp),
        .i_h2c_valid (h2c_valid),
        .i_h2c_beat  (h2c_beat),
        .o_h2c_ready (h2c_ready),
        .o_tx_valid  (tx_valid),
        .o_tx_beat   (tx_beat),
        .i_tx_ready  (tx_ready),
        .i_rx_valid  (rx_valid),
        .i_rx_beat   (rx_beat),
        .o_rx_ready  (rx_ready),
        .o_c2h_valid (c2h_valid),
        .o_c2h_beat  (c2h_beat),
        .i_c2h_ready (c2h_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("Regression failed");
        $fatal(1, reason);
    endtask

    task automatic check_value(input logic [159:0] got, input logic [159:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s, got %0h expected %0h", $time, what, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // ----------------------------------------
    // Timeout and output back-pressure
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run("timeout");
        end
    end

    always @(posedge clk) begin
        tx_ready  <= ($urandom % 4) != 0;
        c2h_ready <= ($urandom % 4) != 0;
    end

    // ----------------------------------------
    // Scoreboards sample between edges
    // ----------------------------------------
    always @(negedge clk) begin
        if (tx_valid && tx_ready) begin
            check_value(160'(exp_h2c.size() != 0), 160'(1), "TX beat with nothing sent");
            check_value(160'(tx_beat), 160'(exp_h2c.pop_front()), "TX beat");
        end
    end

    always @(negedge clk) begin
        if (c2h_valid && c2h_ready) begin
            check_value(160'(exp_c2h.size() != 0), 160'(1), "C2H beat with nothing sent");
            check_value(160'(c2h_beat), 160'(exp_c2h.pop_front()), "C2H beat");
        end
    end

    // Hold counted from the first edge that samples the release
    task automatic wait_rst_done();
        int n;
        n = 0;
        @(posedge clk);
        do begin
            @(negedge clk);
            n++;
        end while (!rst_done);
        check_value(160'(n), 160'(`SNIC_RST_HOLD), "reset hold length");
    endtask

    task automatic module_reset();
        @(posedge clk);
        mod_rstn <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value(160'(rst_done), 160'(0), "reset done during module reset");
        @(posedge clk);
        mod_rstn <= 1'b1;
        wait_rst_done();
    endtask

    // Four-phase access with ack latency counted from the edge that first samples req
    task automatic reg_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata,
                              input logic exp_err);
        int       n;
        reg_cmd_t cmd;
        reg_rsp_t rsp;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.wr    = wr;
        @(posedge clk);
        req     <= 1'b1;
        reg_cmd <= cmd;
        @(posedge clk);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack);
        rsp = reg_rsp;
        check_value(160'(n), 160'(3), "ack latency");
        check_value(160'(rsp.rdata), 160'(exp_rdata), "register rdata");
        check_value(160'(rsp.err), 160'(exp_err), "register err");
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack);
    endtask

    task automatic send_packet(input int path, input int nbeats);
        axis_h2c_beat_t hb;
        axis_c2h_beat_t cb;
        logic           acc;
        @(posedge clk);
        for (int i = 0; i < nbeats; i++) begin
            cb.tdata                = {$urandom, $urandom};
            cb.tkeep                = 8'($urandom);
            cb.tlast                = (i == nbeats - 1);
            cb.tuser.size           = 16'($urandom);
            cb.tuser.src            = 16'($urandom);
            cb.tuser.dst            = 16'($urandom);
            cb.tuser.rss_hash_valid = 1'($urandom);
            cb.tuser.rss_hash       = 12'($urandom);
            hb.tdata      = cb.tdata;
            hb.tkeep      = cb.tkeep;
            hb.tlast      = cb.tlast;
            hb.tuser.size = cb.tuser.size;
            hb.tuser.src  = cb.tuser.src;
            hb.tuser.dst  = cb.tuser.dst;
            if (path == 0) begin
                h2c_valid <= 1'b1;
                h2c_beat  <= hb;
                hb.tuser.dst = `SNIC_H2C_DST;
                exp_h2c.push_back(hb);
            end else begin
                rx_valid <= 1'b1;
                rx_beat  <= cb;
                cb.tuser.dst = `SNIC_C2H_DST;
                exp_c2h.push_back(cb);
            end
            do begin
                @(negedge clk);
                acc = (path == 0) ? h2c_ready : rx_ready;
                @(posedge clk);
            end while (!acc);
        end
        h2c_valid <= 1'b0;
        rx_valid  <= 1'b0;
        // Drain so the counters are settled before any read
        while (exp_h2c.size() != 0 || exp_c2h.size() != 0) @(posedge clk);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(83068));
        rst_n     = 1'b0;
        mod_rstn  = 1'b1;
        req       = 1'b0;
        reg_cmd   = '0;
        h2c_valid = 1'b0;
        h2c_beat  = '0;
        tx_ready  = 1'b0;
        rx_valid  = 1'b0;
        rx_beat   = '0;
        c2h_ready = 1'b0;

        fd = $fopen("verif/smartnic_250mhz_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file verif/smartnic_250mhz_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            s = '0;
            void'($sscanf(line, "%c %h %h %h", s.op, s.a, s.b, s.c));
            cmds.push_back(s);
        end
        $fclose(fd);
        cycle_limit = 40 * cmds.size() + 200;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        wait_rst_done();

        foreach (cmds[i]) begin
            case (cmds[i].op)
                "W": reg_access(1'b1, cmds[i].a, cmds[i].b, 32'h0, cmds[i].c[0]);
                "R": reg_access(1'b0, cmds[i].a, 32'h0, cmds[i].b, cmds[i].c[0]);
                "P": send_packet(int'(cmds[i].a), int'(cmds[i].b));
                "M": module_reset();
                default: abort_run("Unknown command in the stimulus file");
            endcase
        end

        $display("Regression passed");
        $finish;
    end

endmodule : smartnic_250mhz_tb

//--- verilog/axis_reg_slice.sv
module axis_reg_slice #(
    parameter type BEAT_T = logic
) (
    input  logic  i_axis_aclk,
    input  logic  i_core_rst_n,
    input  logic  i_valid,
    input  BEAT_T i_beat,
    output logic  o_ready,
    output logic  o_valid,
    output BEAT_T o_beat,
    input  logic  i_ready
);

    logic  skid_vld;
    logic  skid_vld_d;
    logic  main_vld_d;
    logic  ready_q;
    logic  in_fire;
    logic  main_free;
    BEAT_T skid_beat;

    assign o_ready = ready_q;

    assign in_fire   = i_valid && ready_q;
    // Main register empty or draining this cycle
    assign main_free = !o_valid || i_ready;

    always_comb begin
        main_vld_d = o_valid;
        skid_vld_d = skid_vld;
        if (main_free) begin
            // Skid beat goes first to keep order
            main_vld_d = skid_vld || in_fire;
            skid_vld_d = 1'b0;
        end else if (in_fire) begin
            skid_vld_d = 1'b1;
        end
    end

    always_ff @(posedge i_axis_aclk) begin
        if (!i_core_rst_n) begin
            o_valid  <= 1'b0;
            skid_vld <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            o_valid  <= main_vld_d;
            skid_vld <= skid_vld_d;
            ready_q  <= !skid_vld_d;
        end
    end

    always_ff @(posedge i_axis_aclk) begin
        if (main_free) begin
            o_beat <= skid_vld ? skid_beat : i_beat;
        end else if (in_fire) begin
            skid_beat <= i_beat;
        end
    end

endmodule : axis_reg_slice

//--- verilog/smartnic_250mhz.sv
`include "smartnic_250mhz_consts.svh"

module smartnic_250mhz (
    input  logic                             i_axis_aclk,
    input  logic                             i_rst_n,
    input  logic                             i_mod_rstn,
    output logic                             o_rst_done,

    input  logic                             i_req,
    input  smartnic_reg_pkg::reg_cmd_t       i_reg_cmd,
    output logic                             o_ack,
    output smartnic_reg_pkg::reg_rsp_t       o_reg_rsp,

    input  logic                             i_h2c_valid,
    input  smartnic_axis_pkg::axis_h2c_beat_t i_h2c_beat,
    output logic                             o_h2c_ready,

    output logic                             o_tx_valid,
    output smartnic_axis_pkg::axis_h2c_beat_t o_tx_beat,
    input  logic                             i_tx_ready,

    input  logic                             i_rx_valid,
    input  smartnic_axis_pkg::axis_c2h_beat_t i_rx_beat,
    output logic                             o_rx_ready,

    output logic                             o_c2h_valid,
    output smartnic_axis_pkg::axis_c2h_beat_t o_c2h_beat,
    input  logic                             i_c2h_ready
);

    import smartnic_axis_pkg::*;
    import smartnic_reg_pkg::*;

    logic           core_rst_n;
    reg_op_t        reg_op;
    reg_rsp_t       op_rsp;

    logic           h2c_mid_valid;
    logic           h2c_mid_ready;
    axis_h2c_beat_t h2c_mid_beat;
    axis_h2c_beat_t h2c_mid_fix;

    logic           c2h_mid_valid;
    logic           c2h_mid_ready;
    axis_c2h_beat_t c2h_mid_beat;
    axis_c2h_beat_t c2h_mid_fix;

    // ----------------------------------------
    // Reset and register access
    // ----------------------------------------
    smartnic_250mhz_reset i_smartnic_250mhz_reset (
        .i_axis_aclk  (i_axis_aclk),
        .i_rst_n      (i_rst_n),
        .i_mod_rstn   (i_mod_rstn),
        .o_core_rst_n (core_rst_n),
        .o_rst_done   (o_rst_done)
    );

    smartnic_250mhz_decoder i_smartnic_250mhz_decoder (
        .i_axis_aclk  (i_axis_aclk),
        .i_core_rst_n (core_rst_n),
        .i_req        (i_req),
        .i_reg_cmd    (i_reg_cmd),
        .o_ack        (o_ack),
        .o_reg_rsp    (o_reg_rsp),
        .o_op         (reg_op),
        .i_op_rsp     (op_rsp)
    );

    // Counter taps sit on the path outputs
    smartnic_250mhz_reg_blk i_smartnic_250mhz_reg_blk (
        .i_axis_aclk     (i_axis_aclk),
        .i_core_rst_n    (core_rst_n),
        .i_op            (reg_op),
        .o_op_rsp        (op_rsp),
        .i_h2c_out_valid (o_tx_valid),
        .i_h2c_out_ready (i_tx_ready),
        .i_h2c_out_last  (o_tx_beat.tlast),
        .i_c2h_out_valid (o_c2h_valid),
        .i_c2h_out_ready (i_c2h_ready),
        .i_c2h_out_last  (o_c2h_beat.tlast)
    );

    // ----------------------------------------
    // Port code rewrite between the slices
    // ----------------------------------------
    always_comb begin
        h2c_mid_fix           = h2c_mid_beat;
        h2c_mid_fix.tuser.dst = `SNIC_H2C_DST;
        c2h_mid_fix           = c2h_mid_beat;
        c2h_mid_fix.tuser.dst = `SNIC_C2H_DST;
    end

    // ----------------------------------------
    // H2C path, DMA to adapter TX
    // ----------------------------------------
    axis_reg_slice #(.BEAT_T(axis_h2c_beat_t)) i_axis_reg_slice__qdma_h2c (
        .i_axis_aclk  (i_axis_aclk),
        .i_core_rst_n (core_rst_n),
        .i_valid      (i_h2c_valid),
        .i_beat       (i_h2c_beat),
        .o_ready      (o_h2c_ready),
        .o_valid      (h2c_mid_valid),
        .o_beat       (h2c_mid_beat),
        .i_ready      (h2c_mid_ready)
    );

    axis_reg_slice #(.BEAT_T(axis_h2c_beat_t)) i_axis_reg_slice__adap_tx (
        .i_axis_aclk  (i_axis_aclk),
        .i_core_rst_n (core_rst_n),
        .i_valid      (h2c_mid_valid),
        .i_beat       (h2c_mid_fix),
        .o_ready      (h2c_mid_ready),
        .o_valid      (o_tx_valid),
        .o_beat       (o_tx_beat),
        .i_ready      (i_tx_ready)
    );

    // ----------------------------------------
    // C2H path, adapter RX to DMA
    // ----------------------------------------
    axis_reg_slice #(.BEAT_T(axis_c2h_beat_t)) i_axis_reg_slice__adap_rx (
        .i_axis_aclk  (i_axis_aclk),
        .i_core_rst_n (core_rst_n),
        .i_valid      (i_rx_valid),
        .i_beat       (i_rx_beat),
        .o_ready      (o_rx_ready),
        .o_valid      (c2h_mid_valid),
        .o_beat       (c2h_mid_beat),
        .i_ready      (c2h_mid_ready)
    );

    axis_reg_slice #(.BEAT_T(axis_c2h_beat_t)) i_axis_reg_slice__qdma_c2h (
        .i_axis_aclk  (i_axis_aclk),
        .i_core_rst_n (core_rst_n),
        .i_valid      (c2h_mid_valid),
        .i_beat       (c2h_mid_fix),
        .o_ready      (c2h_mid_ready),
        .o_valid      (o_c2h_valid),
        .o_beat       (o_c2h_beat),
        .i_ready      (i_c2h_ready)
    );

endmodule : smartnic_250mhz

//--- verilog/smartnic_250mhz_reset.sv
`include "smartnic_250mhz_consts.svh"

module smartnic_250mhz_reset (
    input  logic i_axis_aclk,
    input  logic i_rst_n,
    input  logic i_mod_rstn,
    output logic o_core_rst_n,
    output logic o_rst_done
);

    localparam int HOLD  = `SNIC_RST_HOLD;
    localparam int CNT_W = $clog2(HOLD + 1);

    logic             rst_req;
    logic [CNT_W-1:0] hold_cnt;
    logic             done_q;

    // Either source restarts the hold
    assign rst_req = !i_rst_n || !i_mod_rstn;

    always_ff @(posedge i_axis_aclk) begin
        if (rst_req) begin
            hold_cnt <= '0;
            done_q   <= 1'b0;
        end else if (!done_q) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == CNT_W'(HOLD - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    // Core release and done move together
    assign o_core_rst_n = done_q;
    assign o_rst_done   = done_q;

endmodule : smartnic_250mhz_reset
